// ==== Bender.yml ====
package:
  name: clk_control

sources:
  - common/clkPkg.sv
  - logic/clkApbRegs.sv
  - logic/clkRunControl.sv
  - logic/clkSyncDetect.sv
  - logic/clkErrorCheck.sv
  - logic/clkTop.sv
  - target: simulation
    files:
      - sim/clkTb.sv

// ==== common/clkPkg.sv ====
// Clock-control unit shared definitions
// Register map, function opcodes, run states and bundled signal types
`default_nettype none

package clkPkg;

  // Bus and field widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;
  localparam int TIME_W = 2;
  localparam int RATE_W = 2;

  // Register word addresses
  localparam logic [APB_ADDR_W-1:0] ADDR_CMD = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_RATE = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_BURST = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_DISABLE = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_CHECK = 8'h10;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h14;
  localparam logic [APB_ADDR_W-1:0] ADDR_ERRCLR = 8'h18;

  // Function opcodes written to ADDR_CMD
  typedef enum logic [2:0] {
    NOP = 3'd0,
    START = 3'd1,
    STOP = 3'd2,
    SINGLE_STEP = 3'd3,
    EBOX_SS = 3'd4,
    BURST = 3'd5,
    RESET_ON = 3'd6,
    RESET_OFF = 3'd7
  } clkFunc_e;

  typedef enum logic [1:0] {
    STOPPED = 2'd0,
    RUNNING = 2'd1,
    BURSTING = 2'd2,
    STEPPING = 2'd3
  } runState_e;

  // Configuration held by the register block
  typedef struct packed {
    logic [RATE_W-1:0] rateDiv;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
    logic fmParCheck;
    logic cramParCheck;
    logic dramParCheck;
    logic errStopEn;
    logic spare;
  } clkConfig_t;

  typedef struct packed {
    logic valid;
    clkFunc_e op;
  } clkCmd_t;

  typedef struct packed {
    logic ebox;
    logic crm;
    logic edp;
    logic ctl;
  } sectionEn_t;

  // Parity-good flags from the datapath
  typedef struct packed {
    logic fmOk;
    logic cramOk;
    logic dramOk;
  } parityIn_t;

  typedef struct packed {
    logic fmErr;
    logic cramErr;
    logic dramErr;
  } errFlags_t;

endpackage

`default_nettype wire

// ==== logic/clkApbRegs.sv ====
// Clock-control APB register block
// Holds configuration, turns writes into command strobes and reads back status
`default_nettype none
`timescale 1ns/1ps

module clkApbRegs #(
  parameter int BURST_WIDTH = 8
) (
  input wire logic CLK,
  input wire logic reset,
  input wire logic PSEL,
  input wire logic PENABLE,
  input wire logic PWRITE,
  input wire logic [clkPkg::APB_ADDR_W-1:0] PADDR,
  input wire logic [clkPkg::APB_DATA_W-1:0] PWDATA,
  output logic [clkPkg::APB_DATA_W-1:0] PRDATA,
  output logic PREADY,
  output logic PSLVERR,
  input wire clkPkg::runState_e runState,
  input wire logic [BURST_WIDTH-1:0] burstRemaining,
  input wire clkPkg::errFlags_t errFlags,
  input wire logic mrReset,
  output clkPkg::clkConfig_t cfg,
  output clkPkg::clkCmd_t cmd,
  output logic burstLoad,
  output logic [BURST_WIDTH-1:0] burstValue,
  output logic errClear
);

  logic access;
  logic wrEn;
  logic addrErr;
  logic [clkPkg::APB_DATA_W-1:0] rdData;

  assign access = PSEL && PENABLE;
  assign wrEn = access && PWRITE && !addrErr;

  // Zero wait states
  assign PREADY = 1'b1;
  assign PSLVERR = access && addrErr;
  assign PRDATA = rdData;

  // Address decode and read mux
  always_comb begin
    addrErr = 1'b0;
    rdData = '0;
    case (PADDR)
      clkPkg::ADDR_CMD: addrErr = !PWRITE;
      clkPkg::ADDR_RATE: rdData[clkPkg::RATE_W-1:0] = cfg.rateDiv;
      clkPkg::ADDR_BURST: rdData[BURST_WIDTH-1:0] = burstRemaining;
      clkPkg::ADDR_DISABLE: rdData[2:0] = {cfg.ctlDis, cfg.edpDis, cfg.crmDis};
      clkPkg::ADDR_CHECK: begin
        rdData[4:0] = {cfg.spare, cfg.errStopEn, cfg.dramParCheck,
                       cfg.cramParCheck, cfg.fmParCheck};
      end
      clkPkg::ADDR_STATUS: begin
        addrErr = PWRITE;
        rdData[5:0] = {mrReset, errFlags, runState};
      end
      clkPkg::ADDR_ERRCLR: addrErr = !PWRITE;
      default: addrErr = 1'b1;
    endcase
  end

  // Configuration and one-cycle strobes
  always_ff @(posedge CLK) begin
    if (reset) begin
      cfg <= '0;
      cmd <= '0;
      burstLoad <= 1'b0;
      errClear <= 1'b0;
    end else begin
      cmd.valid <= wrEn && (PADDR == clkPkg::ADDR_CMD);
      cmd.op <= clkPkg::clkFunc_e'(PWDATA[2:0]);
      burstLoad <= wrEn && (PADDR == clkPkg::ADDR_BURST);
      errClear <= wrEn && (PADDR == clkPkg::ADDR_ERRCLR);
      if (wrEn) begin
        case (PADDR)
          clkPkg::ADDR_RATE: cfg.rateDiv <= PWDATA[clkPkg::RATE_W-1:0];
          clkPkg::ADDR_DISABLE: {cfg.ctlDis, cfg.edpDis, cfg.crmDis} <= PWDATA[2:0];
          clkPkg::ADDR_CHECK: begin
            {cfg.spare, cfg.errStopEn, cfg.dramParCheck,
             cfg.cramParCheck, cfg.fmParCheck} <= PWDATA[4:0];
          end
          default: ;
        endcase
      end
    end
  end

  // Burst length travels with burstLoad
  always_ff @(posedge CLK) begin
    if (reset) begin
      burstValue <= '0;
    end else if (wrEn && PADDR == clkPkg::ADDR_BURST) begin
      burstValue <= PWDATA[BURST_WIDTH-1:0];
    end
  end

  // Access phase always follows a selected setup phase
  penableNeedsPsel: assert property (
    @(posedge CLK) disable iff (reset) $rose(PENABLE) |-> PSEL
  ) else $error("PENABLE rose without PSEL");

endmodule

`default_nettype wire

// ==== logic/clkErrorCheck.sv ====
// Parity-error capture
// Sticky parity flags sampled at EBOX clock time and the error-stop request
`default_nettype none
`timescale 1ns/1ps

module clkErrorCheck (
  input wire logic CLK,
  input wire logic reset,
  input wire clkPkg::sectionEn_t sectionEn,
  input wire clkPkg::parityIn_t parity,
  input wire clkPkg::clkConfig_t cfg,
  input wire logic errClear,
  output clkPkg::errFlags_t errFlags,
  output logic errorStop
);

  clkPkg::errFlags_t detected;

  // Bad parity counts only where its check is enabled
  always_comb begin
    detected.fmErr = cfg.fmParCheck && !parity.fmOk;
    detected.cramErr = cfg.cramParCheck && !parity.cramOk;
    detected.dramErr = cfg.dramParCheck && !parity.dramOk;
  end

  // Flags stay set until software clears them
  always_ff @(posedge CLK) begin
    if (reset) begin
      errFlags <= '0;
    end else if (errClear) begin
      errFlags <= '0;
    end else if (sectionEn.ebox) begin
      errFlags.fmErr <= errFlags.fmErr || detected.fmErr;
      errFlags.cramErr <= errFlags.cramErr || detected.cramErr;
      errFlags.dramErr <= errFlags.dramErr || detected.dramErr;
    end
  end

  assign errorStop = cfg.errStopEn && (errFlags.fmErr || errFlags.cramErr || errFlags.dramErr);

endmodule

`default_nettype wire

// ==== logic/clkRunControl.sv ====
// Clock run control
// Run state machine, rate divider, burst counter and master-reset flip-flop
`default_nettype none
`timescale 1ns/1ps

module clkRunControl #(
  parameter int BURST_WIDTH = 8
) (
  input wire logic CLK,
  input wire logic reset,
  input wire clkPkg::clkCmd_t cmd,
  input wire clkPkg::clkConfig_t cfg,
  input wire logic burstLoad,
  input wire logic [BURST_WIDTH-1:0] burstValue,
  input wire logic stepDone,
  input wire logic errorStop,
  output logic gatedTick,
  output clkPkg::runState_e runState,
  output logic [BURST_WIDTH-1:0] burstRemaining,
  output logic mrReset
);

  // Divider reaches 2**(2**RATE_W - 1) cycles
  localparam int DIV_W = 2 ** clkPkg::RATE_W - 1;

  logic [DIV_W-1:0] divCount;
  logic [DIV_W-1:0] tickMask;
  logic divDone;
  logic eboxSs;

  assign tickMask = DIV_W'((1 << cfg.rateDiv) - 1);
  assign divDone = divCount >= tickMask;

  // An EBOX step ends with its own enable, so no extra tick then
  assign gatedTick = (runState != clkPkg::STOPPED) && divDone
                     && !(runState == clkPkg::STEPPING && eboxSs && stepDone);

  always_ff @(posedge CLK) begin
    if (reset) begin
      divCount <= '0;
    end else if (cmd.valid || runState == clkPkg::STOPPED || divDone) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      runState <= clkPkg::STOPPED;
      eboxSs <= 1'b0;
    end else if (errorStop) begin
      runState <= clkPkg::STOPPED;
    end else if (cmd.valid) begin
      case (cmd.op)
        clkPkg::START: runState <= clkPkg::RUNNING;
        clkPkg::STOP: runState <= clkPkg::STOPPED;
        clkPkg::SINGLE_STEP: begin
          runState <= clkPkg::STEPPING;
          eboxSs <= 1'b0;
        end
        clkPkg::EBOX_SS: begin
          runState <= clkPkg::STEPPING;
          eboxSs <= 1'b1;
        end
        clkPkg::BURST: begin
          runState <= (burstRemaining == '0) ? clkPkg::STOPPED : clkPkg::BURSTING;
        end
        default: ;
      endcase
    end else begin
      case (runState)
        clkPkg::BURSTING: begin
          if (gatedTick && burstRemaining == BURST_WIDTH'(1)) begin
            runState <= clkPkg::STOPPED;
          end
        end
        clkPkg::STEPPING: begin
          if (eboxSs ? stepDone : gatedTick) begin
            runState <= clkPkg::STOPPED;
          end
        end
        default: ;
      endcase
    end
  end

  // Burst down-counter
  always_ff @(posedge CLK) begin
    if (reset) begin
      burstRemaining <= '0;
    end else if (burstLoad) begin
      burstRemaining <= burstValue;
    end else if (runState == clkPkg::BURSTING && gatedTick) begin
      burstRemaining <= burstRemaining - 1'b1;
    end
  end

  // Master reset set and cleared only by command
  always_ff @(posedge CLK) begin
    if (reset) begin
      mrReset <= 1'b0;
    end else if (cmd.valid && cmd.op == clkPkg::RESET_ON) begin
      mrReset <= 1'b1;
    end else if (cmd.valid && cmd.op == clkPkg::RESET_OFF) begin
      mrReset <= 1'b0;
    end
  end

  noTickWhenStopped: assert property (
    @(posedge CLK) disable iff (reset) gatedTick |-> runState != clkPkg::STOPPED
  ) else $error("gatedTick while STOPPED");

endmodule

`default_nettype wire

// ==== logic/clkSyncDetect.sv ====
// EBOX phase-sync detector
// Counts ticks against the time field, holds on memory wait, drives section enables
`default_nettype none
`timescale 1ns/1ps

module clkSyncDetect (
  input wire logic CLK,
  input wire logic reset,
  input wire logic gatedTick,
  input wire logic [clkPkg::TIME_W-1:0] timeField,
  input wire logic mboxWait,
  input wire logic mboxResp,
  input wire clkPkg::clkConfig_t cfg,
  output clkPkg::sectionEn_t sectionEn,
  output logic stepDone
);

  logic [clkPkg::TIME_W-1:0] tickCount;
  logic respSeen;
  logic syncReached;
  logic fire;

  // This tick completes the microword time
  assign syncReached = gatedTick && (tickCount >= timeField);

  // Outstanding memory wait holds the EBOX clock until a response
  assign fire = syncReached && (!mboxWait || mboxResp || respSeen);

  assign stepDone = sectionEn.ebox;

  always_ff @(posedge CLK) begin
    if (reset) begin
      tickCount <= '0;
    end else if (fire) begin
      tickCount <= '0;
    end else if (gatedTick && !syncReached) begin
      tickCount <= tickCount + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      respSeen <= 1'b0;
    end else if (fire || !mboxWait) begin
      respSeen <= 1'b0;
    end else if (mboxResp) begin
      respSeen <= 1'b1;
    end
  end

  // Enables come out the cycle after the sync tick
  always_ff @(posedge CLK) begin
    if (reset) begin
      sectionEn <= '0;
    end else begin
      sectionEn.ebox <= fire;
      sectionEn.crm <= fire && !cfg.crmDis;
      sectionEn.edp <= fire && !cfg.edpDis;
      sectionEn.ctl <= fire && !cfg.ctlDis;
    end
  end

  sectionNeedsEbox: assert property (
    @(posedge CLK) disable iff (reset)
      (sectionEn.crm || sectionEn.edp || sectionEn.ctl) |-> sectionEn.ebox
  ) else $error("Section enable without EBOX enable");

endmodule

`default_nettype wire

// ==== logic/clkTop.sv ====
// Clock-control unit top level
// APB register block, run control, phase-sync detector and parity checker
`default_nettype none
`timescale 1ns/1ps

module clkTop #(
  parameter int BURST_WIDTH = 8
) (
  input wire logic CLK,
  input wire logic reset,
  input wire logic PSEL,
  input wire logic PENABLE,
  input wire logic PWRITE,
  input wire logic [clkPkg::APB_ADDR_W-1:0] PADDR,
  input wire logic [clkPkg::APB_DATA_W-1:0] PWDATA,
  output logic [clkPkg::APB_DATA_W-1:0] PRDATA,
  output logic PREADY,
  output logic PSLVERR,
  input wire logic [clkPkg::TIME_W-1:0] timeField,
  input wire logic mboxWait,
  input wire logic mboxResp,
  input wire clkPkg::parityIn_t parity,
  output clkPkg::sectionEn_t sectionEn,
  output logic mrReset
);

  clkPkg::clkConfig_t cfg;
  clkPkg::clkCmd_t cmd;
  clkPkg::runState_e runState;
  clkPkg::errFlags_t errFlags;
  logic [BURST_WIDTH-1:0] burstRemaining;
  logic [BURST_WIDTH-1:0] burstValue;
  logic burstLoad;
  logic errClear;
  logic gatedTick;
  logic stepDone;
  logic errorStop;

  clkApbRegs #(.BURST_WIDTH(BURST_WIDTH)) clkApbRegs_inst (
    .CLK(CLK), .reset(reset),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
    .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .runState(runState), .burstRemaining(burstRemaining), .errFlags(errFlags),
    .mrReset(mrReset), .cfg(cfg), .cmd(cmd),
    .burstLoad(burstLoad), .burstValue(burstValue), .errClear(errClear)
  );

  clkRunControl #(.BURST_WIDTH(BURST_WIDTH)) clkRunControl_inst (
    .CLK(CLK), .reset(reset), .cmd(cmd), .cfg(cfg),
    .burstLoad(burstLoad), .burstValue(burstValue),
    .stepDone(stepDone), .errorStop(errorStop), .gatedTick(gatedTick),
    .runState(runState), .burstRemaining(burstRemaining), .mrReset(mrReset)
  );

  clkSyncDetect clkSyncDetect_inst (
    .CLK(CLK), .reset(reset), .gatedTick(gatedTick), .timeField(timeField),
    .mboxWait(mboxWait), .mboxResp(mboxResp), .cfg(cfg),
    .sectionEn(sectionEn), .stepDone(stepDone)
  );

  clkErrorCheck clkErrorCheck_inst (
    .CLK(CLK), .reset(reset), .sectionEn(sectionEn), .parity(parity), .cfg(cfg),
    .errClear(errClear), .errFlags(errFlags), .errorStop(errorStop)
  );

endmodule

`default_nettype wire

// ==== sim/clkTb.sv ====
// Clock-control unit testbench
// Drives APB commands and checks enables, timing, disables and parity capture
`default_nettype none
`timescale 1ns/1ps

module clkTb;

  localparam int BURST_W = 8;
  localparam int NUM_BURSTS = 3;
  localparam int CYCLE_MARGIN = 4000;

  logic CLK;
  logic reset;
  logic PSEL;
  logic PENABLE;
  logic PWRITE;
  logic [clkPkg::APB_ADDR_W-1:0] PADDR;
  logic [clkPkg::APB_DATA_W-1:0] PWDATA;
  logic [clkPkg::APB_DATA_W-1:0] PRDATA;
  logic PREADY;
  logic PSLVERR;
  logic [clkPkg::TIME_W-1:0] timeField;
  logic mboxWait;
  logic mboxResp;
  clkPkg::parityIn_t parity;
  clkPkg::sectionEn_t sectionEn;
  logic mrReset;

  logic [31:0] rngState;
  string testName;
  int errorCount;
  int cycleCount;
  int cycleLimit;
  int eboxCount;
  int lastEnableCycle;
  int expectGap;
  bit spacingArmed;
  logic [2:0] disBits;

  clkTop #(.BURST_WIDTH(BURST_W)) clkTop_inst (
    .CLK(CLK), .reset(reset),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
    .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .timeField(timeField), .mboxWait(mboxWait), .mboxResp(mboxResp), .parity(parity),
    .sectionEn(sectionEn), .mrReset(mrReset)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference model
  function automatic int expectedGap(input int rate, input int tField);
    return (tField + 1) << rate;
  endfunction

  function automatic logic [31:0] expectedStatus(input logic [1:0] state,
                                                 input logic [2:0] flags, input logic mr);
    return {26'd0, mr, flags, state};
  endfunction

  // Disable register holds crm in bit 0, edp in bit 1, ctl in bit 2
  function automatic logic [3:0] expectedSections(input logic ebox, input logic [2:0] dis);
    return {ebox, ebox && !dis[0], ebox && !dis[1], ebox && !dis[2]};
  endfunction

  // Check register has FM in bit 0 while flags and parity carry it in the top bit
  function automatic logic [2:0] expectedFlags(input logic [2:0] chk, input logic [2:0] parOk);
    return {chk[0], chk[1], chk[2]} & ~parOk;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR [%s] %s expected 0x%0h actual 0x%0h", testName, name, expected, actual);
      errorCount++;
    end
  endtask

  // Two-phase APB transfers with the response sampled mid access cycle
  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(posedge CLK);
    PSEL <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE <= 1'b1;
    PADDR <= addr;
    PWDATA <= data;
    @(posedge CLK);
    PENABLE <= 1'b1;
    @(negedge CLK);
    err = PSLVERR;
    checkValue("PREADY", 1, PREADY);
    @(posedge CLK);
    PSEL <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge CLK);
    PSEL <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE <= 1'b0;
    PADDR <= addr;
    @(posedge CLK);
    PENABLE <= 1'b1;
    @(negedge CLK);
    data = PRDATA;
    err = PSLVERR;
    checkValue("PREADY", 1, PREADY);
    @(posedge CLK);
    PSEL <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apbWrite(addr, data, err);
    checkValue("write PSLVERR", 0, err);
  endtask

  task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apbRead(addr, data, err);
    checkValue("read PSLVERR", 0, err);
  endtask

  task automatic sendCmd(input clkPkg::clkFunc_e op);
    writeReg(clkPkg::ADDR_CMD, {29'd0, op});
  endtask

  // Polls status until the run state is back to STOPPED
  task automatic waitStopped;
    logic [31:0] status;
    status = 32'hFFFF_FFFF;
    while (status[1:0] != clkPkg::STOPPED) begin
      readReg(clkPkg::ADDR_STATUS, status);
    end
    repeat (3) @(posedge CLK);
  endtask

  task automatic waitEnables(input int n);
    int target;
    target = eboxCount + n;
    while (eboxCount < target) begin
      @(posedge CLK);
    end
  endtask

  // Enable monitor sampled away from the active edge
  always @(negedge CLK) begin
    if (!reset) begin
      checkValue("section enables", expectedSections(sectionEn.ebox, disBits), sectionEn);
      if (sectionEn.ebox) begin
        if (spacingArmed) begin
          checkValue("ebox spacing", expectGap, cycleCount - lastEnableCycle);
        end
        lastEnableCycle = cycleCount;
        eboxCount++;
      end
    end
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0] value;
    logic [31:0] lastRate;
    logic err;
    int rate;
    int tField;
    int startCount;
    logic [2:0] chk;
    logic [2:0] chkOrder;
    logic [2:0] bad;
    logic [2:0] parOk;
    int burstLen [NUM_BURSTS];

    CLK = 1'b0;
    reset = 1'b1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    timeField = '0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    parity = 3'b111;
    testName = "reset";
    errorCount = 0;
    cycleCount = 0;
    eboxCount = 0;
    lastEnableCycle = 0;
    expectGap = 0;
    spacingArmed = 1'b0;
    disBits = '0;
    rngState = 32'd85921;

    // Burst lengths fixed up front so the cycle limit covers them
    cycleLimit = CYCLE_MARGIN;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      rngState = xorshift(rngState);
      burstLen[i] = rngState % 16 + 1;
      cycleLimit += burstLen[i] * 8 * 4;
    end

    repeat (2) @(posedge CLK);
    reset <= 1'b0;

    testName = "register access";
    for (int i = 0; i < 3; i++) begin
      rngState = xorshift(rngState);
      writeReg(clkPkg::ADDR_RATE, rngState);
      lastRate = rngState & 32'h3;
      readReg(clkPkg::ADDR_RATE, value);
      checkValue("rate readback", lastRate, value);
      rngState = xorshift(rngState);
      writeReg(clkPkg::ADDR_DISABLE, rngState);
      disBits = rngState[2:0];
      readReg(clkPkg::ADDR_DISABLE, value);
      checkValue("disable readback", rngState & 32'h7, value);
      rngState = xorshift(rngState);
      writeReg(clkPkg::ADDR_CHECK, rngState);
      readReg(clkPkg::ADDR_CHECK, value);
      checkValue("check readback", rngState & 32'h1F, value);
    end
    apbWrite(8'h1C, 32'hFFFF_FFFF, err);
    checkValue("unmapped PSLVERR", 1, err);
    readReg(clkPkg::ADDR_RATE, value);
    checkValue("rate after unmapped write", lastRate, value);
    apbWrite(clkPkg::ADDR_STATUS, 32'hFFFF_FFFF, err);
    checkValue("status write PSLVERR", 1, err);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("status unchanged", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b0), value);
    apbRead(clkPkg::ADDR_CMD, value, err);
    checkValue("command read PSLVERR", 1, err);
    writeReg(clkPkg::ADDR_CHECK, 32'h0);

    testName = "burst";
    for (int i = 0; i < NUM_BURSTS; i++) begin
      rngState = xorshift(rngState);
      writeReg(clkPkg::ADDR_RATE, rngState % 4);
      writeReg(clkPkg::ADDR_BURST, burstLen[i]);
      startCount = eboxCount;
      sendCmd(clkPkg::BURST);
      waitStopped();
      checkValue("burst enables", burstLen[i], eboxCount - startCount);
      readReg(clkPkg::ADDR_BURST, value);
      checkValue("burst remaining", 0, value);
      readReg(clkPkg::ADDR_STATUS, value);
      checkValue("burst status", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b0), value);
    end

    testName = "rate and phase";
    for (int i = 0; i < 3; i++) begin
      rngState = xorshift(rngState);
      rate = rngState % 4;
      tField = (rngState >> 8) % 4;
      writeReg(clkPkg::ADDR_RATE, rate);
      @(posedge CLK);
      timeField <= tField[1:0];
      expectGap = expectedGap(rate, tField);
      sendCmd(clkPkg::START);
      readReg(clkPkg::ADDR_STATUS, value);
      checkValue("running status", expectedStatus(clkPkg::RUNNING, 3'b000, 1'b0), value);
      // First interval depends on leftover phase, so spacing starts after it
      waitEnables(1);
      spacingArmed = 1'b1;
      waitEnables(3);
      spacingArmed = 1'b0;
      sendCmd(clkPkg::STOP);
      waitStopped();
    end

    testName = "section disables";
    writeReg(clkPkg::ADDR_RATE, 32'h0);
    @(posedge CLK);
    timeField <= '0;
    for (int i = 0; i < 3; i++) begin
      rngState = xorshift(rngState);
      writeReg(clkPkg::ADDR_DISABLE, rngState);
      disBits = rngState[2:0];
      sendCmd(clkPkg::START);
      waitEnables(8);
      sendCmd(clkPkg::STOP);
      waitStopped();
    end

    testName = "ebox step with wait";
    rngState = xorshift(rngState);
    writeReg(clkPkg::ADDR_RATE, rngState % 4);
    @(posedge CLK);
    mboxWait <= 1'b1;
    startCount = eboxCount;
    sendCmd(clkPkg::EBOX_SS);
    repeat (20) @(posedge CLK);
    checkValue("enables during wait", 0, eboxCount - startCount);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("waiting status", expectedStatus(clkPkg::STEPPING, 3'b000, 1'b0), value);
    @(posedge CLK);
    mboxResp <= 1'b1;
    @(posedge CLK);
    mboxResp <= 1'b0;
    waitStopped();
    checkValue("ebox step enables", 1, eboxCount - startCount);
    @(posedge CLK);
    mboxWait <= 1'b0;

    testName = "single step";
    rngState = xorshift(rngState);
    writeReg(clkPkg::ADDR_RATE, rngState % 4);
    startCount = eboxCount;
    sendCmd(clkPkg::SINGLE_STEP);
    waitStopped();
    checkValue("single step enables", 1, eboxCount - startCount);

    testName = "parity errors";
    rngState = xorshift(rngState);
    chk = rngState % 7 + 1;
    chkOrder = {chk[0], chk[1], chk[2]};
    rngState = xorshift(rngState);
    bad = rngState[2:0] & chkOrder;
    if (bad == 3'b000) begin
      bad = chkOrder;
    end
    // Unchecked sources also carry bad parity
    parOk = chkOrder & ~bad;
    writeReg(clkPkg::ADDR_CHECK, {29'd0, chk});
    @(posedge CLK);
    parity <= parOk;
    sendCmd(clkPkg::SINGLE_STEP);
    waitStopped();
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("flags after step",
               expectedStatus(clkPkg::STOPPED, expectedFlags(chk, parOk), 1'b0), value);
    writeReg(clkPkg::ADDR_ERRCLR, 32'h0);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("flags cleared", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b0), value);

    testName = "error stop";
    writeReg(clkPkg::ADDR_CHECK, {28'd0, 1'b1, chk});
    sendCmd(clkPkg::START);
    waitStopped();
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("stopped by error",
               expectedStatus(clkPkg::STOPPED, expectedFlags(chk, parOk), 1'b0), value);
    writeReg(clkPkg::ADDR_ERRCLR, 32'h0);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("flags cleared", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b0), value);

    testName = "checks disabled";
    writeReg(clkPkg::ADDR_CHECK, 32'h0);
    @(posedge CLK);
    parity <= 3'b000;
    sendCmd(clkPkg::SINGLE_STEP);
    waitStopped();
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("no flags",
               expectedStatus(clkPkg::STOPPED, expectedFlags(3'b000, 3'b000), 1'b0), value);
    @(posedge CLK);
    parity <= 3'b111;

    testName = "master reset";
    sendCmd(clkPkg::RESET_ON);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("status after RESET_ON", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b1), value);
    @(negedge CLK);
    checkValue("mrReset high", 1, mrReset);
    sendCmd(clkPkg::RESET_OFF);
    readReg(clkPkg::ADDR_STATUS, value);
    checkValue("status after RESET_OFF", expectedStatus(clkPkg::STOPPED, 3'b000, 1'b0), value);
    @(negedge CLK);
    checkValue("mrReset low", 0, mrReset);

    repeat (3) @(posedge CLK);
    $display("Run complete after %0d cycles with %0d errors", cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/clkPkg.sv
logic/clkApbRegs.sv
logic/clkRunControl.sv
logic/clkSyncDetect.sv
logic/clkErrorCheck.sv
logic/clkTop.sv
sim/clkTb.sv
